// ==== compile.f ====
logic/ulpb_pkg.sv
logic/ahb_slave_port.sv
logic/tx_queue.sv
logic/rx_fifo.sv
logic/ulpb_node.sv
logic/layer_controller.sv
tb/tb_clock.sv
tb/layer_controller_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module layer_controller_tb -o sim_layer_controller
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_layer_controller > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' sim.log; then
	exit 0
else
	exit 1
fi

// ==== tb/layer_controller_tb.sv ====
`timescale 1ns/1ps

module layer_controller_tb;

	localparam ulpb_pkg::addr_t own_addr = 8'hab;
	localparam int payload_bits = ulpb_pkg::frame_bits - 1;
	// about 12 frames of 44 bit times at 8 cycles, plus idle watches
	localparam int cycle_limit = 20000;

	logic HCLK;
	logic HRESETn;
	logic HSEL;
	logic [31:0] HADDR;
	logic HWRITE;
	logic [2:0] HSIZE;
	logic [1:0] HTRANS;
	logic HREADY;
	logic [31:0] HWDATA;
	logic HREADYOUT;
	logic [1:0] HRESP;
	ulpb_pkg::data_t HRDATA;
	logic DIN;
	logic DOUT;
	logic tx_fail;
	logic tx_succ;
	logic rx_frame_complete;
	logic rx_fifo_empty;

	logic [2:0] sclk_cnt = 3'd0;
	logic SCLK = 1'b0;
	logic [31:0] lfsr_state = 32'h2289;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int succ_count = 0;
	int fail_count = 0;
	int fc_count = 0;
	logic succ_prev = 1'b0;
	logic fail_prev = 1'b0;

	tb_clock clk_gen (
		.HCLK(HCLK),
		.HRESETn(HRESETn)
	);

	layer_controller #(
		.node_address(own_addr),
		.address_mask(8'hff),
		.tx_depth(8),
		.rx_depth(8)
	) uut (
		.HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR), .HWRITE(HWRITE),
		.HSIZE(HSIZE), .HTRANS(HTRANS), .HREADY(HREADY), .HWDATA(HWDATA),
		.HREADYOUT(HREADYOUT), .HRESP(HRESP), .HRDATA(HRDATA),
		.SCLK(SCLK), .DIN(DIN), .DOUT(DOUT), .tx_fail(tx_fail), .tx_succ(tx_succ),
		.rx_frame_complete(rx_frame_complete), .rx_fifo_empty(rx_fifo_empty)
	);

	// bit strobe, four cycles high and four low
	always @(posedge HCLK)
	begin
		sclk_cnt <= sclk_cnt + 3'd1;
		SCLK <= ~sclk_cnt[2];
	end

	// result levels are short, so count their rising edges
	always @(posedge HCLK)
	begin
		cycles <= cycles + 1;
		succ_prev <= tx_succ;
		fail_prev <= tx_fail;
		if (tx_succ && !succ_prev)
			succ_count <= succ_count + 1;
		if (tx_fail && !fail_prev)
			fail_count <= fail_count + 1;
		if (rx_frame_complete)
			fc_count <= fc_count + 1;
		if (cycles >= cycle_limit)
		begin
			$display("run stopped by timeout after %0d cycles, %0d errors", cycles, errors);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic ulpb_pkg::data_t rand_word();
		ulpb_pkg::data_t w;
		int i;
		w = '0;
		for (i = 0; i < ulpb_pkg::DATA_W; i++)
		begin
			w = {w[ulpb_pkg::DATA_W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return w;
	endfunction

	task automatic check_data(input string name, input ulpb_pkg::data_t got,
		input ulpb_pkg::data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input ulpb_pkg::addr_t got,
		input ulpb_pkg::addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic ahb_xfer(input logic write, input logic [31:0] addr,
		input ulpb_pkg::data_t wdata, output ulpb_pkg::data_t rdata);
		int waits;
		@(posedge HCLK);
		HSEL <= 1'b1;
		HADDR <= addr;
		HWRITE <= write;
		HSIZE <= 3'b010;
		HTRANS <= 2'b10;
		@(posedge HCLK);
		HSEL <= 1'b0;
		HTRANS <= 2'b00;
		HWDATA <= wdata;
		waits = 0;
		do
		begin
			@(posedge HCLK);
			waits++;
		end while (HREADYOUT !== 1'b1 && waits < 16);
		if (HREADYOUT !== 1'b1)
		begin
			errors++;
			$display("AHB transfer to %h did not complete, HREADYOUT stuck low", addr);
		end
		// always OKAY
		check_data("HRESP", {30'h0, HRESP}, '0);
		rdata = HRDATA;
	endtask

	task automatic ahb_write(input ulpb_pkg::addr_t dest, input ulpb_pkg::data_t wdata);
		ulpb_pkg::data_t unused;
		ahb_xfer(1'b1, {20'h0, dest, 4'h0}, wdata, unused);
	endtask

	task automatic ahb_read(output ulpb_pkg::data_t rdata);
		ahb_xfer(1'b0, 32'h0, '0, rdata);
	endtask

	// edge where SCLK goes low
	task automatic wait_sclk_fall;
		@(posedge HCLK);
		while (sclk_cnt != 3'd4)
			@(posedge HCLK);
	endtask

	// far end taking a frame from DOUT and answering in the ack slot
	task automatic remote_receive(input logic ack_bit, input int max_periods,
		output logic found, output ulpb_pkg::addr_t addr, output ulpb_pkg::data_t data,
		output logic pend);
		logic [payload_bits-1:0] bits;
		int n;
		int i;
		found = 1'b0;
		bits = '0;
		n = 0;
		while (!found && n < max_periods)
		begin
			wait_sclk_fall;
			n++;
			if (DOUT === 1'b0)
				found = 1'b1;
		end
		if (found)
		begin
			for (i = 0; i < payload_bits; i++)
			begin
				wait_sclk_fall;
				bits = {bits[payload_bits-2:0], DOUT};
			end
			DIN <= ack_bit;
			wait_sclk_fall;
			DIN <= 1'b1;
		end
		addr = bits[payload_bits-1 -: ulpb_pkg::ADDR_W];
		data = bits[ulpb_pkg::DATA_W:1];
		pend = bits[0];
	endtask

	// far end sending a frame on DIN, then reading the ack bit
	task automatic remote_send(input ulpb_pkg::addr_t addr, input ulpb_pkg::data_t data,
		input logic pend, output logic acked);
		logic [payload_bits-1:0] frame;
		int i;
		frame = {addr, data, pend};
		wait_sclk_fall;
		DIN <= 1'b0;
		for (i = payload_bits - 1; i >= 0; i--)
		begin
			wait_sclk_fall;
			DIN <= frame[i];
		end
		wait_sclk_fall;
		DIN <= 1'b1;
		wait_sclk_fall;
		acked = (DOUT === 1'b0);
	endtask

	task automatic wait_tx_results(input int target);
		int n;
		n = 0;
		while (succ_count + fail_count < target && n < 64)
		begin
			@(posedge HCLK);
			n++;
		end
		if (succ_count + fail_count < target)
		begin
			errors++;
			$display("no transmit result from the node within 64 cycles");
		end
	endtask

	task automatic wait_rx_word;
		int n;
		n = 0;
		while (rx_fifo_empty !== 1'b0 && n < 64)
		begin
			@(posedge HCLK);
			n++;
		end
		if (rx_fifo_empty !== 1'b0)
		begin
			errors++;
			$display("received word never reached the receive FIFO");
		end
	endtask

	task automatic test_reset_and_wait;
		logic found;
		ulpb_pkg::addr_t a;
		ulpb_pkg::data_t d;
		logic p;
		int i;
		check_bit("HREADYOUT", HREADYOUT, 1'b1);
		check_bit("DOUT", DOUT, 1'b1);
		check_bit("tx_succ", tx_succ, 1'b0);
		check_bit("tx_fail", tx_fail, 1'b0);
		check_bit("rx_frame_complete", rx_frame_complete, 1'b0);
		check_bit("rx_fifo_empty", rx_fifo_empty, 1'b1);
		@(posedge HCLK);
		HSEL <= 1'b1;
		HADDR <= 32'h0;
		HWRITE <= 1'b0;
		HSIZE <= 3'b010;
		HTRANS <= 2'b10;
		@(posedge HCLK);
		HSEL <= 1'b0;
		HTRANS <= 2'b00;
		for (i = 0; i < 4; i++)
		begin
			@(posedge HCLK);
			check_bit("HREADYOUT", HREADYOUT, 1'b0);
		end
		@(posedge HCLK);
		check_bit("HREADYOUT", HREADYOUT, 1'b1);
		check_data("HRDATA", HRDATA, '0);
		// byte write, zero wait and nothing queued
		HSEL <= 1'b1;
		HADDR <= 32'h120;
		HWRITE <= 1'b1;
		HSIZE <= 3'b000;
		HTRANS <= 2'b10;
		@(posedge HCLK);
		HSEL <= 1'b0;
		HTRANS <= 2'b00;
		HSIZE <= 3'b010;
		HWDATA <= 32'h5a5a_0f0f;
		for (i = 0; i < 3; i++)
		begin
			@(posedge HCLK);
			check_bit("HREADYOUT", HREADYOUT, 1'b1);
		end
		remote_receive(1'b0, 4, found, a, d, p);
		check_bit("DOUT frame after byte write", found, 1'b0);
	endtask

	task automatic test_single_write;
		ulpb_pkg::data_t exp;
		ulpb_pkg::addr_t a;
		ulpb_pkg::data_t d;
		logic p;
		logic found;
		int succ0;
		int fail0;
		exp = rand_word();
		succ0 = succ_count;
		fail0 = fail_count;
		ahb_write(8'h12, exp);
		remote_receive(1'b0, 20, found, a, d, p);
		check_bit("DOUT start bit", found, 1'b1);
		check_addr("frame address", a, 8'h12);
		check_data("frame data", d, exp);
		check_bit("frame pending", p, 1'b0);
		wait_tx_results(succ0 + fail0 + 1);
		check_bit("tx_succ rose", succ_count == succ0 + 1, 1'b1);
		check_bit("tx_fail rose", fail_count != fail0, 1'b0);
	endtask

	task automatic test_pending_bits;
		ulpb_pkg::addr_t exp_addr [4];
		ulpb_pkg::data_t exp_data [4];
		logic exp_pend [4];
		ulpb_pkg::addr_t a;
		ulpb_pkg::data_t d;
		logic p;
		logic found;
		int succ0;
		int i;
		int j;
		exp_addr = '{8'h21, 8'h34, 8'h34, 8'h56};
		exp_pend = '{1'b0, 1'b1, 1'b0, 1'b0};
		for (i = 0; i < 4; i++)
			exp_data[i] = rand_word();
		succ0 = succ_count;
		// later words queue while the first frame is on the wire
		fork
			begin
				for (i = 0; i < 4; i++)
					ahb_write(exp_addr[i], exp_data[i]);
			end
			begin
				for (j = 0; j < 4; j++)
				begin
					remote_receive(1'b0, 20, found, a, d, p);
					check_bit("DOUT start bit", found, 1'b1);
					check_addr("frame address", a, exp_addr[j]);
					check_data("frame data", d, exp_data[j]);
					check_bit("frame pending", p, exp_pend[j]);
				end
			end
		join
		wait_tx_results(succ0 + fail_count + 4);
		check_bit("tx_succ count", succ_count - succ0 == 4, 1'b1);
	endtask

	task automatic test_nack_flush;
		ulpb_pkg::addr_t a;
		ulpb_pkg::data_t d;
		ulpb_pkg::data_t d0;
		logic p;
		logic found;
		int succ0;
		int fail0;
		d0 = rand_word();
		succ0 = succ_count;
		fail0 = fail_count;
		fork
			begin
				ahb_write(8'h41, d0);
				ahb_write(8'h42, rand_word());
			end
			begin
				remote_receive(1'b1, 20, found, a, d, p);
				check_bit("DOUT start bit", found, 1'b1);
				check_addr("frame address", a, 8'h41);
				check_data("frame data", d, d0);
			end
		join
		wait_tx_results(succ0 + fail0 + 1);
		check_bit("tx_fail rose", fail_count == fail0 + 1, 1'b1);
		check_bit("tx_succ rose", succ_count != succ0, 1'b0);
		remote_receive(1'b0, 60, found, a, d, p);
		check_bit("DOUT frame after flush", found, 1'b0);
	endtask

	task automatic test_receive_filter;
		ulpb_pkg::data_t exp;
		ulpb_pkg::data_t rd;
		logic acked;
		exp = rand_word();
		remote_send(own_addr, exp, 1'b0, acked);
		check_bit("DOUT ack", acked, 1'b1);
		wait_rx_word;
		ahb_read(rd);
		check_data("HRDATA", rd, exp);
		check_bit("rx_fifo_empty", rx_fifo_empty, 1'b1);
		remote_send(8'h3c, rand_word(), 1'b0, acked);
		check_bit("DOUT ack", acked, 1'b0);
		repeat (16)
			@(posedge HCLK);
		check_bit("rx_fifo_empty", rx_fifo_empty, 1'b1);
		ahb_read(rd);
		check_data("HRDATA", rd, '0);
	endtask

	task automatic test_frame_complete;
		ulpb_pkg::data_t d1;
		ulpb_pkg::data_t d2;
		ulpb_pkg::data_t rd;
		logic acked;
		int fc0;
		int n;
		d1 = rand_word();
		d2 = rand_word();
		fc0 = fc_count;
		remote_send(own_addr, d1, 1'b1, acked);
		check_bit("DOUT ack", acked, 1'b1);
		remote_send(own_addr, d2, 1'b0, acked);
		check_bit("DOUT ack", acked, 1'b1);
		n = 0;
		while (fc_count == fc0 && n < 64)
		begin
			@(posedge HCLK);
			n++;
		end
		if (fc_count == fc0)
		begin
			errors++;
			$display("rx_frame_complete never pulsed after the last word");
		end
		repeat (16)
			@(posedge HCLK);
		check_bit("rx_frame_complete single pulse", fc_count - fc0 == 1, 1'b1);
		ahb_read(rd);
		check_data("HRDATA first word", rd, d1);
		ahb_read(rd);
		check_data("HRDATA second word", rd, d2);
		check_bit("rx_fifo_empty", rx_fifo_empty, 1'b1);
	endtask

	initial
	begin
		HSEL = 1'b0;
		HADDR = '0;
		HWRITE = 1'b0;
		HSIZE = 3'b010;
		HTRANS = 2'b00;
		HREADY = 1'b1;
		HWDATA = '0;
		DIN = 1'b1;
		wait (HRESETn === 1'b1);
		@(posedge HCLK);
		test_reset_and_wait;
		test_single_write;
		test_pending_bits;
		test_nack_flush;
		test_receive_filter;
		test_frame_complete;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic HCLK,
	output logic HRESETn
);

	// 100 ns period
	initial
	begin
		HCLK = 1'b0;
		forever
			#50 HCLK = ~HCLK;
	end

	// reset held over three rising edges
	initial
	begin
		HRESETn = 1'b0;
		repeat (3)
			@(posedge HCLK);
		HRESETn <= 1'b1;
	end

endmodule

// ==== logic/layer_controller.sv ====
`timescale 1ns/1ps

module layer_controller #(
	parameter ulpb_pkg::addr_t node_address = 8'hab,
	parameter ulpb_pkg::addr_t address_mask = 8'hff,
	parameter int tx_depth = 8,
	parameter int rx_depth = 8
) (
	input logic HCLK,
	input logic HRESETn,
	input logic HSEL,
	input logic [31:0] HADDR,
	input logic HWRITE,
	input logic [2:0] HSIZE,
	input logic [1:0] HTRANS,
	input logic HREADY,
	input logic [31:0] HWDATA,
	output logic HREADYOUT,
	output logic [1:0] HRESP,
	output ulpb_pkg::data_t HRDATA,
	input logic SCLK,
	input logic DIN,
	output logic DOUT,
	output logic tx_fail,
	output logic tx_succ,
	output logic rx_frame_complete,
	output logic rx_fifo_empty
);

	logic push;
	logic pop;
	ulpb_pkg::addr_t push_addr;
	ulpb_pkg::data_t push_data;
	ulpb_pkg::data_t rx_q;
	ulpb_pkg::addr_t tx_addr;
	ulpb_pkg::data_t tx_data;
	ulpb_pkg::data_t rx_data;
	logic tx_pend;
	logic tx_empty;
	logic tx_full;
	logic rx_full;
	logic tx_req;
	logic tx_ack;
	logic tx_ack_reg;
	logic tx_resp_ack;
	logic tx_advance;
	logic rx_req;
	logic rx_ack;
	logic rx_pend;
	logic rx_wr;
	logic rx_pending;
	ulpb_pkg::link_state_t tx_state;
	ulpb_pkg::link_state_t rx_state;

	assign HRESP = 2'b00;
	assign tx_advance = (tx_state == ulpb_pkg::link_wait) && tx_ack_reg;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			tx_state <= ulpb_pkg::link_idle;
			tx_req <= 1'b0;
			tx_ack_reg <= 1'b0;
			tx_resp_ack <= 1'b0;
		end
		else
		begin
			tx_ack_reg <= tx_ack;
			tx_resp_ack <= tx_succ || tx_fail;
			case (tx_state)
				ulpb_pkg::link_idle:
				begin
					if (!tx_empty && !tx_ack_reg)
					begin
						tx_req <= 1'b1;
						tx_state <= ulpb_pkg::link_wait;
					end
				end
				ulpb_pkg::link_wait:
				begin
					// queue flushed under a waiting request
					if (tx_ack_reg || tx_empty)
					begin
						tx_req <= 1'b0;
						tx_state <= ulpb_pkg::link_idle;
					end
				end
				default:
				begin
					tx_state <= ulpb_pkg::link_idle;
				end
			endcase
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			rx_state <= ulpb_pkg::link_idle;
			rx_ack <= 1'b0;
			rx_wr <= 1'b0;
			rx_pending <= 1'b0;
			rx_frame_complete <= 1'b0;
		end
		else
		begin
			rx_frame_complete <= 1'b0;
			case (rx_state)
				ulpb_pkg::link_idle:
				begin
					if (rx_req && !rx_full)
					begin
						rx_ack <= 1'b1;
						rx_wr <= 1'b1;
						rx_pending <= rx_pend;
						rx_state <= ulpb_pkg::link_wait;
					end
				end
				ulpb_pkg::link_wait:
				begin
					rx_wr <= 1'b0;
					if (!rx_req && rx_ack)
					begin
						rx_ack <= 1'b0;
						rx_frame_complete <= !rx_pending;
						rx_state <= ulpb_pkg::link_idle;
					end
				end
				default:
				begin
					rx_state <= ulpb_pkg::link_idle;
				end
			endcase
		end
	end

	ahb_slave_port u_ahb (
		.HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR), .HWRITE(HWRITE),
		.HSIZE(HSIZE), .HTRANS(HTRANS), .HREADY(HREADY), .HWDATA(HWDATA),
		.HREADYOUT(HREADYOUT), .HRDATA(HRDATA),
		.push(push), .push_addr(push_addr), .push_data(push_data), .pop(pop),
		.rx_q(rx_q), .tx_full(tx_full), .rx_empty(rx_fifo_empty)
	);

	tx_queue #(.tx_depth(tx_depth)) u_tx_queue (
		.HCLK(HCLK), .HRESETn(HRESETn), .push(push), .push_addr(push_addr),
		.push_data(push_data), .advance(tx_advance), .flush(tx_fail),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend),
		.tx_empty(tx_empty), .tx_full(tx_full)
	);

	rx_fifo #(.rx_depth(rx_depth)) u_rx_fifo (
		.HCLK(HCLK), .HRESETn(HRESETn), .wr(rx_wr), .wdata(rx_data), .rd(pop),
		.q(rx_q), .empty(rx_fifo_empty), .full(rx_full)
	);

	// address filtering happens in the node
	ulpb_node #(.node_address(node_address), .address_mask(address_mask)) u_node (
		.HCLK(HCLK), .HRESETn(HRESETn), .SCLK(SCLK), .DIN(DIN), .DOUT(DOUT),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend), .tx_req(tx_req),
		.tx_ack(tx_ack), .tx_succ(tx_succ), .tx_fail(tx_fail), .tx_resp_ack(tx_resp_ack),
		.rx_addr(), .rx_data(rx_data), .rx_pend(rx_pend), .rx_req(rx_req), .rx_ack(rx_ack)
	);

endmodule

// ==== logic/ulpb_node.sv ====
`timescale 1ns/1ps

module ulpb_node #(
	parameter ulpb_pkg::addr_t node_address = 8'hab,
	parameter ulpb_pkg::addr_t address_mask = 8'hff
) (
	input logic HCLK,
	input logic HRESETn,
	input logic SCLK,
	input logic DIN,
	output logic DOUT,
	input ulpb_pkg::addr_t tx_addr,
	input ulpb_pkg::data_t tx_data,
	input logic tx_pend,
	input logic tx_req,
	output logic tx_ack,
	output logic tx_succ,
	output logic tx_fail,
	input logic tx_resp_ack,
	output ulpb_pkg::addr_t rx_addr,
	output ulpb_pkg::data_t rx_data,
	output logic rx_pend,
	output logic rx_req,
	input logic rx_ack
);

	localparam int fb = ulpb_pkg::frame_bits;
	localparam int cnt_w = $clog2(fb + 1);
	localparam logic [cnt_w-1:0] frame_end = cnt_w'(fb);

	ulpb_pkg::node_state_t state;
	logic [1:0] sclk_s;
	logic sclk_rise;
	logic [fb-1:0] sr;
	logic [cnt_w-1:0] bit_cnt;
	logic start_rx;
	logic start_tx;
	logic send_bit;
	logic recv_bit;
	logic addr_hit;

	assign sclk_rise = sclk_s[0] && !sclk_s[1];

	// start bit on the wire beats a local request
	assign start_rx = (state == ulpb_pkg::n_idle) && sclk_rise && !DIN;
	assign start_tx = (state == ulpb_pkg::n_idle) && sclk_rise && DIN && tx_req && !tx_ack
		&& !tx_resp_ack;
	assign send_bit = (state == ulpb_pkg::n_send) && sclk_rise && (bit_cnt != frame_end);
	assign recv_bit = (state == ulpb_pkg::n_recv) && sclk_rise && (bit_cnt != frame_end);

	// received frame sits in the low bits, start bit not stored
	assign rx_addr = sr[fb-2 -: ulpb_pkg::ADDR_W];
	assign rx_data = sr[ulpb_pkg::DATA_W:1];
	assign rx_pend = sr[0];
	assign addr_hit = ((rx_addr ^ node_address) & address_mask) == '0;

	always_ff @(posedge HCLK)
	begin
		if (start_tx)
			sr <= {1'b0, tx_addr, tx_data, tx_pend};
		else if (send_bit)
			sr <= {sr[fb-2:0], 1'b1};
		else if (recv_bit)
			sr <= {sr[fb-2:0], DIN};
	end

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			state <= ulpb_pkg::n_idle;
			sclk_s <= '0;
			bit_cnt <= '0;
			DOUT <= 1'b1;
			tx_ack <= 1'b0;
			tx_succ <= 1'b0;
			tx_fail <= 1'b0;
			rx_req <= 1'b0;
		end
		else
		begin
			sclk_s <= {sclk_s[0], SCLK};
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;
			if (rx_req && rx_ack)
				rx_req <= 1'b0;
			case (state)
				ulpb_pkg::n_idle:
				begin
					if (start_rx)
					begin
						bit_cnt <= cnt_w'(1);
						state <= ulpb_pkg::n_recv;
					end
					else if (start_tx)
					begin
						tx_ack <= 1'b1;
						bit_cnt <= '0;
						state <= ulpb_pkg::n_send;
					end
				end
				ulpb_pkg::n_send:
				begin
					if (send_bit)
					begin
						DOUT <= sr[fb-1];
						bit_cnt <= bit_cnt + 1'b1;
					end
					else if (sclk_rise)
					begin
						// acknowledge slot from the remote
						DOUT <= 1'b1;
						tx_succ <= !DIN;
						tx_fail <= DIN;
						state <= ulpb_pkg::n_resp;
					end
				end
				ulpb_pkg::n_resp:
				begin
					if (tx_resp_ack)
					begin
						tx_succ <= 1'b0;
						tx_fail <= 1'b0;
						state <= ulpb_pkg::n_idle;
					end
				end
				ulpb_pkg::n_recv:
				begin
					if (recv_bit)
						bit_cnt <= bit_cnt + 1'b1;
					else if (sclk_rise)
					begin
						if (addr_hit)
						begin
							DOUT <= 1'b0;
							rx_req <= 1'b1;
							state <= ulpb_pkg::n_ack;
						end
						else
							state <= ulpb_pkg::n_idle;
					end
				end
				ulpb_pkg::n_ack:
				begin
					if (sclk_rise)
						DOUT <= 1'b1;
					// held here while the controller cannot take the word
					if (DOUT && !rx_req && !rx_ack)
						state <= ulpb_pkg::n_idle;
				end
				default:
				begin
					state <= ulpb_pkg::n_idle;
				end
			endcase
		end
	end

endmodule

// ==== logic/rx_fifo.sv ====
`timescale 1ns/1ps

module rx_fifo #(
	parameter int rx_depth = 8
) (
	input logic HCLK,
	input logic HRESETn,
	input logic wr,
	input ulpb_pkg::data_t wdata,
	input logic rd,
	output ulpb_pkg::data_t q,
	output logic empty,
	output logic full
);

	localparam int ptr_w = $clog2(rx_depth);

	ulpb_pkg::data_t mem [rx_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (count == (ptr_w + 1)'(rx_depth));
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;
	// show-ahead head word
	assign q = mem[rd_ptr];

	always_ff @(posedge HCLK)
	begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== logic/tx_queue.sv ====
`timescale 1ns/1ps

module tx_queue #(
	parameter int tx_depth = 8
) (
	input logic HCLK,
	input logic HRESETn,
	input logic push,
	input ulpb_pkg::addr_t push_addr,
	input ulpb_pkg::data_t push_data,
	input logic advance,
	input logic flush,
	output ulpb_pkg::addr_t tx_addr,
	output ulpb_pkg::data_t tx_data,
	output logic tx_pend,
	output logic tx_empty,
	output logic tx_full
);

	localparam int ptr_w = $clog2(tx_depth);

	ulpb_pkg::addr_t addr_mem [tx_depth];
	ulpb_pkg::data_t data_mem [tx_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] next_rd;
	logic [ptr_w:0] count;
	logic do_push;
	logic do_pop;

	assign tx_empty = (count == '0);
	assign tx_full = (count == (ptr_w + 1)'(tx_depth));
	assign do_push = push && !tx_full;
	assign do_pop = advance && !tx_empty;
	assign next_rd = rd_ptr + 1'b1;

	assign tx_addr = addr_mem[rd_ptr];
	assign tx_data = data_mem[rd_ptr];
	// next word to the same node keeps the frame open
	assign tx_pend = (count > (ptr_w + 1)'(1)) && (addr_mem[next_rd] == addr_mem[rd_ptr]);

	always_ff @(posedge HCLK)
	begin
		if (do_push)
		begin
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= next_rd;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== logic/ahb_slave_port.sv ====
`timescale 1ns/1ps

module ahb_slave_port (
	input logic HCLK,
	input logic HRESETn,
	input logic HSEL,
	input logic [31:0] HADDR,
	input logic HWRITE,
	input logic [2:0] HSIZE,
	input logic [1:0] HTRANS,
	input logic HREADY,
	input logic [31:0] HWDATA,
	output logic HREADYOUT,
	output ulpb_pkg::data_t HRDATA,
	output logic push,
	output ulpb_pkg::addr_t push_addr,
	output ulpb_pkg::data_t push_data,
	output logic pop,
	input ulpb_pkg::data_t rx_q,
	input logic tx_full,
	input logic rx_empty
);

	ulpb_pkg::ahb_state_t state;
	logic is_write;
	logic accept;
	ulpb_pkg::data_t rd_word;

	// word transfers only, anything else completes with no wait
	assign accept = HSEL && HREADY && HTRANS[1] && (HSIZE == 3'b010);

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			state <= ulpb_pkg::idle;
			HREADYOUT <= 1'b1;
			HRDATA <= '0;
			is_write <= 1'b0;
			push <= 1'b0;
			pop <= 1'b0;
		end
		else
		begin
			case (state)
				ulpb_pkg::idle:
				begin
					if (accept)
					begin
						is_write <= HWRITE;
						HREADYOUT <= 1'b0;
						state <= ulpb_pkg::capture;
					end
				end
				ulpb_pkg::capture:
				begin
					// full queue or empty fifo drops the transfer
					if (is_write)
						push <= !tx_full;
					else
						pop <= !rx_empty;
					state <= ulpb_pkg::strobe;
				end
				ulpb_pkg::strobe:
				begin
					push <= 1'b0;
					pop <= 1'b0;
					state <= ulpb_pkg::settle;
				end
				ulpb_pkg::settle:
				begin
					state <= ulpb_pkg::respond;
				end
				ulpb_pkg::respond:
				begin
					HRDATA <= rd_word;
					HREADYOUT <= 1'b1;
					state <= ulpb_pkg::idle;
				end
				default:
				begin
					state <= ulpb_pkg::idle;
				end
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (state == ulpb_pkg::idle && accept)
			push_addr <= HADDR[11:4];
		if (state == ulpb_pkg::capture)
			push_data <= HWDATA;
		// head word before the pop lands
		if (state == ulpb_pkg::strobe)
			rd_word <= pop ? rx_q : '0;
	end

endmodule

// ==== logic/ulpb_pkg.sv ====
package ulpb_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// start bit, address, data, pending bit
	localparam int frame_bits = 1 + ADDR_W + DATA_W + 1;

	typedef enum logic [2:0] {
		idle,
		capture,
		strobe,
		settle,
		respond
	} ahb_state_t;

	typedef enum logic {
		link_idle,
		link_wait
	} link_state_t;

	typedef enum logic [2:0] {
		n_idle,
		n_send,
		n_resp,
		n_recv,
		n_ack
	} node_state_t;

endpackage
